// File: logic/buffer_geom_pkg.sv
`default_nettype none

package buffer_geom_pkg;

	// data widths on either side of the packer
	typedef logic [15:0] sample_t;
	typedef logic [31:0] word_t;

	////////////////////
	// buffer sizes
	////////////////////

	// input ring counts samples, output ring counts words
	localparam int IN_DEPTH_SAMPLES = 64;
	localparam int OUT_DEPTH_WORDS = 64;
	localparam int MEM_DEPTH_WORDS = 256;
	localparam int IN_PTR_W = $clog2(IN_DEPTH_SAMPLES);
	localparam int OUT_PTR_W = $clog2(OUT_DEPTH_WORDS);

	// longest transfer the mover does in one go
	localparam int BURST_WORDS = 4;
	// output level at which the host may fetch a block
	localparam int BLOCK_WORDS = 16;

	// bulk memory word address, wraps at the top
	typedef logic [7:0] mem_addr_t;
	// level counts, one bit wider than the pointers so full fits
	typedef logic [6:0] in_count_t;
	typedef logic [6:0] out_count_t;
	// words held in bulk memory
	typedef logic [15:0] mem_count_t;
	// total sample count reported to the host
	typedef logic [31:0] occupancy_t;

endpackage

`default_nettype wire

// File: logic/buffer_ctrl_pkg.sv
`default_nettype none

package buffer_ctrl_pkg;

	////////////////////
	// mover FSM
	////////////////////

	// write bursts fill memory, read bursts empty it into the output ring
	// read_drain catches the word still coming back from the RAM
	typedef enum logic [1:0] {
		IDLE,
		WRITE_BURST,
		READ_BURST,
		READ_DRAIN
	} mover_state_e;

	////////////////////
	// memory port
	////////////////////

	typedef enum logic [1:0] {
		MEM_NOP,
		MEM_WRITE,
		MEM_READ
	} mem_op_e;

	// one command per cycle, 42 bits
	typedef struct packed {
		mem_op_e op;
		buffer_geom_pkg::mem_addr_t addr;
		buffer_geom_pkg::word_t wdata;
	} mem_cmd_t;

	// levels gathered for the occupancy count, 30 bits
	// in_count is in samples, the other two in 32-bit words
	typedef struct packed {
		buffer_geom_pkg::mem_count_t mem_words;
		buffer_geom_pkg::in_count_t in_count;
		buffer_geom_pkg::out_count_t out_count;
	} level_snapshot_t;

endpackage

`default_nettype wire

// File: logic/sample_pack_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sample_pack_fifo (
	input wire ti_clk,
	input wire rst,
	input wire wr_en,
	input wire buffer_geom_pkg::sample_t din,
	input wire rd_en,
	output buffer_geom_pkg::word_t dout,
	output buffer_geom_pkg::in_count_t word_count,
	output buffer_geom_pkg::in_count_t sample_count
);

	// sample storage
	buffer_geom_pkg::sample_t ring [buffer_geom_pkg::IN_DEPTH_SAMPLES];
	logic [buffer_geom_pkg::IN_PTR_W-1:0] wr_ptr;
	logic [buffer_geom_pkg::IN_PTR_W-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	// writes into a full ring are lost
	assign wr_ok = wr_en &&
		(sample_count != buffer_geom_pkg::in_count_t'(buffer_geom_pkg::IN_DEPTH_SAMPLES));
	// a pop takes a whole pair, never a lone sample
	assign rd_ok = rd_en && (word_count != '0);

	always_ff @(posedge ti_clk) begin
		if (wr_ok) begin
			ring[wr_ptr] <= din;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			sample_count <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 2'd2;
			end
			// push and pop may land in the same cycle
			sample_count <= sample_count
				+ buffer_geom_pkg::in_count_t'(wr_ok)
				- (rd_ok ? buffer_geom_pkg::in_count_t'(2) : buffer_geom_pkg::in_count_t'(0));
		end
	end

	// head pair shown without a register
	// older sample goes to the upper half
	assign dout = {ring[rd_ptr], ring[rd_ptr + 1'b1]};

	// an odd trailing sample stays in sample_count but not here
	assign word_count = sample_count >> 1;

endmodule

`default_nettype wire

// File: logic/burst_mover.sv
`timescale 1ns/100ps
`default_nettype none

module burst_mover (
	input wire ti_clk,
	input wire rst,
	input wire buffer_geom_pkg::word_t in_word,
	input wire buffer_geom_pkg::in_count_t in_word_count,
	input wire buffer_geom_pkg::out_count_t out_free_count,
	input wire buffer_geom_pkg::word_t mem_rdata,
	output logic in_rd_en,
	output buffer_ctrl_pkg::mem_cmd_t mem_cmd,
	output logic out_wr_en,
	output buffer_geom_pkg::word_t out_wdata,
	output buffer_geom_pkg::mem_count_t mem_words
);

	buffer_ctrl_pkg::mover_state_e state;
	// words left in the running burst
	buffer_geom_pkg::in_count_t burst_left;
	// circular pointers into bulk memory
	buffer_geom_pkg::mem_addr_t wr_addr;
	buffer_geom_pkg::mem_addr_t rd_addr;
	// last burst was a write, used for alternation
	logic wrote_last;
	logic can_write;
	logic can_read;
	logic start_write;
	buffer_geom_pkg::in_count_t write_len;
	buffer_geom_pkg::in_count_t read_len;

	////////////////////
	// burst decision
	////////////////////

	// at least one packed word waiting upstream
	assign can_write = (in_word_count != '0);
	// data stored and room downstream for a full burst
	assign can_read = (mem_words != '0) &&
		(out_free_count >= buffer_geom_pkg::out_count_t'(buffer_geom_pkg::BURST_WORDS));
	// when both are possible take turns, write wins after reset
	assign start_write = can_write && (!can_read || !wrote_last);

	// burst length is clamped to what is available
	assign write_len = (in_word_count >= buffer_geom_pkg::in_count_t'(buffer_geom_pkg::BURST_WORDS))
		? buffer_geom_pkg::in_count_t'(buffer_geom_pkg::BURST_WORDS)
		: in_word_count;
	assign read_len = (mem_words >= buffer_geom_pkg::mem_count_t'(buffer_geom_pkg::BURST_WORDS))
		? buffer_geom_pkg::in_count_t'(buffer_geom_pkg::BURST_WORDS)
		: buffer_geom_pkg::in_count_t'(mem_words);

	////////////////////
	// memory command
	////////////////////

	// pop the input head in the same cycle it is written to RAM
	assign in_rd_en = (state == buffer_ctrl_pkg::WRITE_BURST);

	always_comb begin
		mem_cmd.op = buffer_ctrl_pkg::MEM_NOP;
		mem_cmd.addr = wr_addr;
		mem_cmd.wdata = in_word;
		case (state)
			buffer_ctrl_pkg::WRITE_BURST: begin
				mem_cmd.op = buffer_ctrl_pkg::MEM_WRITE;
			end
			buffer_ctrl_pkg::READ_BURST: begin
				mem_cmd.op = buffer_ctrl_pkg::MEM_READ;
				mem_cmd.addr = rd_addr;
			end
			default: begin
			end
		endcase
	end

	// RAM data is valid the cycle after the read, pass it straight on
	assign out_wdata = mem_rdata;

	////////////////////
	// FSM and pointers
	////////////////////

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			state <= buffer_ctrl_pkg::IDLE;
			burst_left <= '0;
			wr_addr <= '0;
			rd_addr <= '0;
			mem_words <= '0;
			wrote_last <= 1'b0;
			out_wr_en <= 1'b0;
		end else begin
			// one output write per read issued last cycle
			out_wr_en <= (state == buffer_ctrl_pkg::READ_BURST);
			case (state)
				buffer_ctrl_pkg::IDLE: begin
					if (start_write) begin
						state <= buffer_ctrl_pkg::WRITE_BURST;
						burst_left <= write_len;
						wrote_last <= 1'b1;
					end else if (can_read) begin
						state <= buffer_ctrl_pkg::READ_BURST;
						burst_left <= read_len;
						wrote_last <= 1'b0;
					end
				end
				buffer_ctrl_pkg::WRITE_BURST: begin
					// address wraps, overflow laps unread data
					wr_addr <= wr_addr + 1'b1;
					mem_words <= mem_words + 1'b1;
					burst_left <= burst_left - 1'b1;
					if (burst_left == buffer_geom_pkg::in_count_t'(1)) begin
						state <= buffer_ctrl_pkg::IDLE;
					end
				end
				buffer_ctrl_pkg::READ_BURST: begin
					rd_addr <= rd_addr + 1'b1;
					mem_words <= mem_words - 1'b1;
					burst_left <= burst_left - 1'b1;
					if (burst_left == buffer_geom_pkg::in_count_t'(1)) begin
						state <= buffer_ctrl_pkg::READ_DRAIN;
					end
				end
				// last word of the burst is forwarded here
				default: begin
					state <= buffer_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/bulk_memory.sv
`timescale 1ns/100ps
`default_nettype none

module bulk_memory (
	input wire ti_clk,
	input wire buffer_ctrl_pkg::mem_cmd_t mem_cmd,
	output buffer_geom_pkg::word_t rdata
);

	// on-chip stand-in for the SDRAM
	buffer_geom_pkg::word_t ram [buffer_geom_pkg::MEM_DEPTH_WORDS];

	// single port, one command per cycle
	// read data shows up one cycle after MEM_READ and then holds
	always_ff @(posedge ti_clk) begin
		case (mem_cmd.op)
			buffer_ctrl_pkg::MEM_WRITE: begin
				ram[mem_cmd.addr] <= mem_cmd.wdata;
			end
			buffer_ctrl_pkg::MEM_READ: begin
				rdata <= ram[mem_cmd.addr];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/host_out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module host_out_fifo (
	input wire ti_clk,
	input wire rst,
	input wire wr_en,
	input wire buffer_geom_pkg::word_t din,
	input wire rd_en,
	output buffer_geom_pkg::word_t dout,
	output buffer_geom_pkg::out_count_t out_count,
	output buffer_geom_pkg::out_count_t free_count,
	output logic out_rdy
);

	buffer_geom_pkg::word_t ring [buffer_geom_pkg::OUT_DEPTH_WORDS];
	logic [buffer_geom_pkg::OUT_PTR_W-1:0] wr_ptr;
	logic [buffer_geom_pkg::OUT_PTR_W-1:0] rd_ptr;
	logic rd_ok;

	// empty read does nothing, dout keeps the last word
	assign rd_ok = rd_en && (out_count != '0);

	// mover only writes when free_count allows it
	always_ff @(posedge ti_clk) begin
		if (wr_en) begin
			ring[wr_ptr] <= din;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			out_count <= '0;
			dout <= '0;
			out_rdy <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
				dout <= ring[rd_ptr];
			end
			out_count <= out_count
				+ buffer_geom_pkg::out_count_t'(wr_en)
				- buffer_geom_pkg::out_count_t'(rd_ok);
			// block ready, one cycle behind the level
			out_rdy <= (out_count >= buffer_geom_pkg::out_count_t'(buffer_geom_pkg::BLOCK_WORDS));
		end
	end

	// room left for read bursts
	assign free_count = buffer_geom_pkg::out_count_t'(buffer_geom_pkg::OUT_DEPTH_WORDS) - out_count;

endmodule

`default_nettype wire

// File: logic/occupancy_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module occupancy_monitor (
	input wire ti_clk,
	input wire rst,
	input wire buffer_ctrl_pkg::level_snapshot_t levels,
	output buffer_geom_pkg::occupancy_t num_words
);

	buffer_geom_pkg::occupancy_t mem_samples;
	buffer_geom_pkg::occupancy_t out_samples;
	buffer_geom_pkg::occupancy_t in_samples;

	// every level converted to 16-bit samples
	// memory term comes from the stored count, so a full RAM is not seen as empty
	assign mem_samples = buffer_geom_pkg::occupancy_t'(levels.mem_words) << 1;
	assign out_samples = buffer_geom_pkg::occupancy_t'(levels.out_count) << 1;
	// input ring is already in samples, lone sample included
	assign in_samples = buffer_geom_pkg::occupancy_t'(levels.in_count);

	// registered sum, lags level changes by a cycle
	// words in flight from RAM to the output ring drop out briefly
	always_ff @(posedge ti_clk) begin
		if (rst) begin
			num_words <= '0;
		end else begin
			num_words <= mem_samples + out_samples + in_samples;
		end
	end

endmodule

`default_nettype wire

// File: logic/stream_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none

module stream_buffer_top (
	input wire ti_clk,
	input wire rst,
	input wire fifo_write_to,
	input wire buffer_geom_pkg::sample_t fifo_data_in,
	input wire fifo_read_from,
	output buffer_geom_pkg::word_t fifo_data_out,
	output logic fifo_out_rdy,
	output buffer_geom_pkg::occupancy_t num_words_in_fifo
);

	// input side
	buffer_geom_pkg::word_t in_word;
	buffer_geom_pkg::in_count_t in_word_count;
	buffer_geom_pkg::in_count_t in_sample_count;
	logic in_rd_en;
	// bulk memory
	buffer_ctrl_pkg::mem_cmd_t mem_cmd;
	buffer_geom_pkg::word_t mem_rdata;
	buffer_geom_pkg::mem_count_t mem_words;
	// output side
	logic out_wr_en;
	buffer_geom_pkg::word_t out_wdata;
	buffer_geom_pkg::out_count_t out_count;
	buffer_geom_pkg::out_count_t out_free_count;
	buffer_ctrl_pkg::level_snapshot_t levels;

	////////////////////
	// data path
	////////////////////

	sample_pack_fifo i_in_fifo (
		.ti_clk (ti_clk),
		.rst (rst),
		.wr_en (fifo_write_to),
		.din (fifo_data_in),
		.rd_en (in_rd_en),
		.dout (in_word),
		.word_count (in_word_count),
		.sample_count (in_sample_count)
	);

	burst_mover i_mover (
		.ti_clk (ti_clk),
		.rst (rst),
		.in_word (in_word),
		.in_word_count (in_word_count),
		.out_free_count (out_free_count),
		.mem_rdata (mem_rdata),
		.in_rd_en (in_rd_en),
		.mem_cmd (mem_cmd),
		.out_wr_en (out_wr_en),
		.out_wdata (out_wdata),
		.mem_words (mem_words)
	);

	bulk_memory i_mem (
		.ti_clk (ti_clk),
		.mem_cmd (mem_cmd),
		.rdata (mem_rdata)
	);

	// host reads here, never stalled
	host_out_fifo i_out_fifo (
		.ti_clk (ti_clk),
		.rst (rst),
		.wr_en (out_wr_en),
		.din (out_wdata),
		.rd_en (fifo_read_from),
		.dout (fifo_data_out),
		.out_count (out_count),
		.free_count (out_free_count),
		.out_rdy (fifo_out_rdy)
	);

	////////////////////
	// occupancy
	////////////////////

	assign levels = '{mem_words: mem_words, in_count: in_sample_count, out_count: out_count};

	occupancy_monitor i_occupancy (
		.ti_clk (ti_clk),
		.rst (rst),
		.levels (levels),
		.num_words (num_words_in_fifo)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic ti_clk
);

	// 40 ns period, 25 MHz
	localparam int HALF_PERIOD_NS = 20;

	initial begin
		ti_clk = 1'b0;
	end

	// free running, starts low
	always begin
		#(HALF_PERIOD_NS) ti_clk = ~ti_clk;
	end

endmodule

`default_nettype wire

// File: verif/stream_buffer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stream_buffer_tb;

	// kinds of table steps
	typedef enum logic [2:0] {
		ACT_WRITE,
		ACT_READ,
		ACT_READ_EMPTY,
		ACT_STREAM,
		ACT_DRAIN,
		ACT_SETTLE,
		ACT_CHECK_COUNT,
		ACT_CHECK_RDY
	} step_act_e;

	// one table row, n is a strobe count, expected is used by the checks
	typedef struct packed {
		step_act_e act;
		logic [15:0] n;
		buffer_geom_pkg::occupancy_t expected;
	} step_t;

	logic ti_clk;
	logic rst;
	logic fifo_write_to;
	buffer_geom_pkg::sample_t fifo_data_in;
	logic fifo_read_from;
	buffer_geom_pkg::word_t fifo_data_out;
	logic fifo_out_rdy;
	buffer_geom_pkg::occupancy_t num_words_in_fifo;

	step_t steps[$];
	// reference model, every sample written and not yet read back
	buffer_geom_pkg::sample_t model_q[$];
	buffer_geom_pkg::word_t last_word;
	int unsigned pass_count;
	int unsigned fail_count;

	tb_clock_gen i_clk_gen (
		.ti_clk (ti_clk)
	);

	stream_buffer_top i_dut (
		.ti_clk (ti_clk),
		.rst (rst),
		.fifo_write_to (fifo_write_to),
		.fifo_data_in (fifo_data_in),
		.fifo_read_from (fifo_read_from),
		.fifo_data_out (fifo_data_out),
		.fifo_out_rdy (fifo_out_rdy),
		.num_words_in_fifo (num_words_in_fifo)
	);

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_word(input string name, input buffer_geom_pkg::word_t expected,
		input buffer_geom_pkg::word_t actual);
		if (actual === expected) begin
			pass_count++;
		end else begin
			fail_count++;
			$display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input buffer_geom_pkg::occupancy_t expected,
		input buffer_geom_pkg::occupancy_t actual);
		if (actual === expected) begin
			pass_count++;
		end else begin
			fail_count++;
			$display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual === expected) begin
			pass_count++;
		end else begin
			fail_count++;
			$display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
		end
	endtask

	////////////////////
	// stimulus and model
	////////////////////

	// drive slot, 5 ns after the rising edge
	task automatic next_slot();
		@(posedge ti_clk);
		#5;
	endtask

	// oldest pair from the model, older sample in the upper half
	function automatic buffer_geom_pkg::word_t pop_pair();
		buffer_geom_pkg::word_t w;
		w = {model_q[0], model_q[1]};
		void'(model_q.pop_front());
		void'(model_q.pop_front());
		return w;
	endfunction

	// data settle bound, doubled for margin
	function automatic int settle_cycles(input int words);
		return 2 * (words / buffer_geom_pkg::BURST_WORDS + 1) * (buffer_geom_pkg::BURST_WORDS + 3);
	endfunction

	task automatic write_samples(input int n);
		buffer_geom_pkg::sample_t s;
		for (int i = 0; i < n; i++) begin
			s = buffer_geom_pkg::sample_t'($urandom());
			fifo_write_to = 1'b1;
			fifo_data_in = s;
			model_q.push_back(s);
			next_slot();
		end
		fifo_write_to = 1'b0;
	endtask

	// back to back reads, dout checked one cycle after each strobe
	task automatic read_words(input int n);
		buffer_geom_pkg::word_t expected;
		for (int i = 0; i < n; i++) begin
			fifo_read_from = 1'b1;
			expected = pop_pair();
			next_slot();
			check_word("fifo_data_out", expected, fifo_data_out);
			last_word = expected;
		end
		fifo_read_from = 1'b0;
	endtask

	// output FIFO empty, dout must repeat the last word
	task automatic read_empty();
		fifo_read_from = 1'b1;
		next_slot();
		fifo_read_from = 1'b0;
		check_word("fifo_data_out", last_word, fifo_data_out);
	endtask

	// one sample every 3 cycles, a word fetched after each pair
	// host only reads while a block is ready, so no empty reads here
	task automatic stream_samples(input int n);
		buffer_geom_pkg::sample_t s;
		buffer_geom_pkg::word_t expected;
		logic do_read;
		for (int i = 0; i < n; i++) begin
			s = buffer_geom_pkg::sample_t'($urandom());
			fifo_write_to = 1'b1;
			fifo_data_in = s;
			model_q.push_back(s);
			do_read = (i % 2 == 1) && fifo_out_rdy;
			if (do_read) begin
				fifo_read_from = 1'b1;
				expected = pop_pair();
			end
			next_slot();
			fifo_write_to = 1'b0;
			fifo_read_from = 1'b0;
			if (do_read) begin
				check_word("fifo_data_out", expected, fifo_data_out);
				last_word = expected;
			end
			next_slot();
			next_slot();
		end
	endtask

	////////////////////
	// step table
	////////////////////

	function automatic void add_step(input step_act_e act, input int n, input int expected);
		step_t st;
		st.act = act;
		st.n = 16'(n);
		st.expected = buffer_geom_pkg::occupancy_t'(expected);
		steps.push_back(st);
	endfunction

	// worst case cycles for one step
	function automatic int step_budget(input step_t st);
		int cycles;
		case (st.act)
			ACT_WRITE, ACT_READ: cycles = int'(st.n);
			ACT_STREAM: cycles = 3 * int'(st.n);
			ACT_DRAIN: cycles = buffer_geom_pkg::OUT_DEPTH_WORDS;
			ACT_SETTLE: cycles = settle_cycles(buffer_geom_pkg::OUT_DEPTH_WORDS);
			default: cycles = 1;
		endcase
		return cycles;
	endfunction

	task automatic build_table();
		// empty after reset
		add_step(ACT_CHECK_COUNT, 0, 0);
		add_step(ACT_CHECK_RDY, 0, 0);
		// 2 x BLOCK_WORDS samples give a ready block
		add_step(ACT_WRITE, 32, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_RDY, 0, 1);
		add_step(ACT_CHECK_COUNT, 0, 32);
		// one read drops below the block level
		add_step(ACT_READ, 1, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_RDY, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 30);
		add_step(ACT_READ, 15, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 0);
		// 40 samples, then a lone 41st
		add_step(ACT_WRITE, 40, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 40);
		add_step(ACT_WRITE, 1, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 41);
		add_step(ACT_READ, 20, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 1);
		// empty output, dout repeats
		add_step(ACT_READ_EMPTY, 1, 0);
		add_step(ACT_CHECK_COUNT, 0, 1);
		// long stream so the memory addresses wrap
		add_step(ACT_STREAM, 600, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_DRAIN, 0, 0);
		add_step(ACT_SETTLE, 0, 0);
		add_step(ACT_CHECK_COUNT, 0, 1);
		add_step(ACT_CHECK_RDY, 0, 0);
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge ti_clk);
		$display("timeout: the test steps did not finish within %0d clock cycles", cycles);
		$display("Regression failed");
		$finish;
	endtask

	initial begin
		int budget;
		int unsigned fails_before;
		step_t st;
		void'($urandom(87257));
		rst = 1'b1;
		fifo_write_to = 1'b0;
		fifo_data_in = '0;
		fifo_read_from = 1'b0;
		pass_count = 0;
		fail_count = 0;
		last_word = '0;
		build_table();
		// reset plus every step, twice over
		budget = 8;
		foreach (steps[k]) begin
			budget += step_budget(steps[k]);
		end
		fork
			run_watchdog(2 * budget);
		join_none
		repeat (8) @(posedge ti_clk);
		#5;
		rst = 1'b0;
		foreach (steps[k]) begin
			st = steps[k];
			fails_before = fail_count;
			case (st.act)
				ACT_WRITE: write_samples(int'(st.n));
				ACT_READ: read_words(int'(st.n));
				ACT_READ_EMPTY: read_empty();
				ACT_STREAM: stream_samples(int'(st.n));
				ACT_DRAIN: read_words(model_q.size() / 2);
				ACT_SETTLE: repeat (settle_cycles(model_q.size() / 2)) next_slot();
				ACT_CHECK_COUNT: check_count("num_words_in_fifo", st.expected, num_words_in_fifo);
				default: check_flag("fifo_out_rdy", st.expected[0], fifo_out_rdy);
			endcase
			$display("step %0d %s n=%0d: %s", k, st.act.name(), st.n,
				(fail_count == fails_before) ? "ok" : "FAILED");
		end
		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/buffer_geom_pkg.sv
logic/buffer_ctrl_pkg.sv
logic/sample_pack_fifo.sv
logic/burst_mover.sv
logic/bulk_memory.sv
logic/host_out_fifo.sv
logic/occupancy_monitor.sv
logic/stream_buffer_top.sv
verif/tb_clock_gen.sv
verif/stream_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the stream buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module stream_buffer_tb -o sim_stream_buffer
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_stream_buffer)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1
